/* source/matrix_calc_pkg.sv */
package matrix_calc_pkg;

	// ----------------------------------------------------------------------
	// widths and sizes
	// ----------------------------------------------------------------------
	localparam int ELEM_W    = 31;
	localparam int IDX_W     = 4;
	localparam int ADDR_W    = 8;   // {row, col}
	localparam int RAM_DEPTH = 256;

	typedef logic [ELEM_W-1:0] elem_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [IDX_W-1:0]  idx_t;

	// ----------------------------------------------------------------------
	// opcodes and controller states
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		act_setup     = 3'd0,
		act_add       = 3'd1,
		act_mul       = 3'd2,   // reserved, not implemented
		act_transpose = 3'd3,
		act_mirror    = 3'd4,
		act_rotate    = 3'd5
	} action_e;

	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_drain,
		st_permute,
		st_copy,
		st_play,
		st_done
	} state_e;

	// ----------------------------------------------------------------------
	// bundles between the blocks
	// ----------------------------------------------------------------------
	typedef struct packed {
		action_e action;
		idx_t    dim_m1;    // matrix dimension minus one
	} cmd_t;

	typedef struct packed {
		logic  valid;
		idx_t  row;
		idx_t  col;
		elem_t data;
	} beat_t;

	typedef struct packed {
		logic  en;
		logic  we;
		addr_t addr;
		elem_t wdata;
	} ram_req_t;

endpackage

/* source/mc_input_stage.sv */
`timescale 1ns/10ps

module mc_input_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  matrix_calc_pkg::elem_t in_data,
	input  logic [1:0]             size,
	input  logic [2:0]             action,
	output matrix_calc_pkg::cmd_t  cmd,
	output matrix_calc_pkg::beat_t beat,
	output logic                   cmd_end
);

	logic                   in_valid_q;
	logic                   first;
	matrix_calc_pkg::idx_t  row_q, col_q;       // index of the registered beat
	matrix_calc_pkg::idx_t  row_nxt, col_nxt;   // index the next beat gets
	matrix_calc_pkg::idx_t  dim_dec;
	matrix_calc_pkg::elem_t data_q;

	assign first   = in_valid && !in_valid_q;
	assign cmd_end = in_valid_q && !in_valid;   // first idle cycle after a burst
	assign beat    = '{valid: in_valid_q, row: row_q, col: col_q, data: data_q};

	always_comb begin
		case (size)
			2'd0:    dim_dec = 4'd1;
			2'd1:    dim_dec = 4'd3;
			2'd2:    dim_dec = 4'd7;
			default: dim_dec = 4'd15;
		endcase
	end

	// command latch, size only taken on setup
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd <= '{action: matrix_calc_pkg::act_setup, dim_m1: 4'd1};
		end else if (first) begin
			cmd.action <= matrix_calc_pkg::action_e'(action);
			if (matrix_calc_pkg::action_e'(action) == matrix_calc_pkg::act_setup)
				cmd.dim_m1 <= dim_dec;
		end
	end

	// row-major beat index
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid_q <= 1'b0;
			row_q      <= '0;
			col_q      <= '0;
			row_nxt    <= '0;
			col_nxt    <= '0;
		end else begin
			in_valid_q <= in_valid;
			if (first) begin
				row_q   <= '0;
				col_q   <= '0;
				row_nxt <= '0;
				col_nxt <= 4'd1;    // smallest matrix is 2x2
			end else if (in_valid) begin
				row_q <= row_nxt;
				col_q <= col_nxt;
				if (col_nxt == cmd.dim_m1) begin
					col_nxt <= '0;
					row_nxt <= (row_nxt == cmd.dim_m1) ? '0 : row_nxt + 4'd1;
				end else begin
					col_nxt <= col_nxt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		data_q <= in_data;
	end

	a_no_mul : assert property (@(posedge clk) disable iff (!rst_n)
		first |-> matrix_calc_pkg::action_e'(action) != matrix_calc_pkg::act_mul)
		else $error("multiply command is not supported");

endmodule

/* source/mc_add_pipe.sv */
`timescale 1ns/10ps

module mc_add_pipe (
	input  logic                      clk,
	input  logic                      rst_n,
	input  matrix_calc_pkg::beat_t    beat,
	input  matrix_calc_pkg::elem_t    cur_rdata,
	output matrix_calc_pkg::ram_req_t add_req
);

	logic                           valid_q;
	matrix_calc_pkg::addr_t         addr_q;
	matrix_calc_pkg::elem_t         data_q;
	logic [matrix_calc_pkg::ELEM_W:0] sum;     // one extra bit for the carry
	matrix_calc_pkg::elem_t         folded;

	// beat held one cycle to meet the cur_ram read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= beat.valid;
	end

	always_ff @(posedge clk) begin
		addr_q <= {beat.row, beat.col};
		data_q <= beat.data;
	end

	// ----------------------------------------------------------------------
	// end-around carry
	// ----------------------------------------------------------------------
	assign sum    = {1'b0, data_q} + {1'b0, cur_rdata};
	assign folded = sum[matrix_calc_pkg::ELEM_W-1:0] +
	                matrix_calc_pkg::elem_t'(sum[matrix_calc_pkg::ELEM_W]);

	assign add_req = '{en: valid_q, we: 1'b1, addr: addr_q, wdata: folded};

endmodule

/* source/matrix_ram.sv */
`timescale 1ns/10ps

module matrix_ram (
	input  logic                      clk,
	input  matrix_calc_pkg::ram_req_t req,
	output matrix_calc_pkg::elem_t    rdata
);

	matrix_calc_pkg::elem_t mem [matrix_calc_pkg::RAM_DEPTH];

	// single port, read data registered
	always_ff @(posedge clk) begin
		if (req.en) begin
			if (req.we)
				mem[req.addr] <= req.wdata;
			else
				rdata <= mem[req.addr];
		end
	end

	a_we_known : assert property (@(posedge clk)
		req.en |-> !$isunknown(req.we))
		else $error("write enable unknown on an active access");

endmodule

/* source/mc_controller.sv */
`timescale 1ns/10ps

module mc_controller (
	input  logic                      clk,
	input  logic                      rst_n,
	input  matrix_calc_pkg::cmd_t     cmd,
	input  matrix_calc_pkg::beat_t    beat,
	input  logic                      cmd_end,
	input  matrix_calc_pkg::ram_req_t add_req,
	input  matrix_calc_pkg::elem_t    cur_rdata,
	input  matrix_calc_pkg::elem_t    work_rdata,
	output matrix_calc_pkg::ram_req_t cur_req,
	output matrix_calc_pkg::ram_req_t work_req,
	output logic                      rd_sel,
	output logic                      play_rd,
	output logic                      done
);

	matrix_calc_pkg::state_e state, state_nxt, dispatch;
	matrix_calc_pkg::idx_t   scan_row, scan_col;
	matrix_calc_pkg::addr_t  scan_addr, perm_addr;
	logic                    is_add, scan_en, scan_last;
	logic                    scan_rd_cur, scan_rd_work;
	logic                    pend_valid, pend_to_cur;  // copy write one cycle behind its read
	matrix_calc_pkg::addr_t  pend_addr;

	assign is_add    = (cmd.action == matrix_calc_pkg::act_add);
	assign scan_en   = (state == matrix_calc_pkg::st_permute) ||
	                   (state == matrix_calc_pkg::st_copy) ||
	                   (state == matrix_calc_pkg::st_play);
	assign scan_last = (scan_row == cmd.dim_m1) && (scan_col == cmd.dim_m1);
	assign scan_addr = {scan_row, scan_col};

	assign scan_rd_cur  = (state == matrix_calc_pkg::st_permute) ||
	                      (state == matrix_calc_pkg::st_play && !is_add);
	assign scan_rd_work = (state == matrix_calc_pkg::st_copy) ||
	                      (state == matrix_calc_pkg::st_play && is_add);

	assign play_rd = (state == matrix_calc_pkg::st_play);
	assign rd_sel  = is_add;    // add plays back from work_ram
	assign done    = (state == matrix_calc_pkg::st_done);

	// ----------------------------------------------------------------------
	// target of a permuted word, source at (scan_row, scan_col)
	// ----------------------------------------------------------------------
	always_comb begin
		case (cmd.action)
			matrix_calc_pkg::act_transpose: perm_addr = {scan_col, scan_row};
			matrix_calc_pkg::act_mirror:    perm_addr = {scan_row, cmd.dim_m1 - scan_col};
			default:                        perm_addr = {scan_col, cmd.dim_m1 - scan_row};
		endcase
	end

	// where a command goes once its input burst ends
	always_comb begin
		case (cmd.action)
			matrix_calc_pkg::act_setup:     dispatch = matrix_calc_pkg::st_play;
			matrix_calc_pkg::act_add:       dispatch = matrix_calc_pkg::st_drain;
			matrix_calc_pkg::act_transpose,
			matrix_calc_pkg::act_mirror,
			matrix_calc_pkg::act_rotate:    dispatch = matrix_calc_pkg::st_permute;
			default:                        dispatch = matrix_calc_pkg::st_idle;
		endcase
	end

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			matrix_calc_pkg::st_idle: begin
				if (cmd_end)
					state_nxt = dispatch;   // single-beat command
				else if (beat.valid)
					state_nxt = matrix_calc_pkg::st_load;
			end
			matrix_calc_pkg::st_load:
				if (cmd_end) state_nxt = dispatch;
			matrix_calc_pkg::st_drain:  // lets the last write land before the scan
				state_nxt = is_add ? matrix_calc_pkg::st_play : matrix_calc_pkg::st_copy;
			matrix_calc_pkg::st_permute:
				if (scan_last) state_nxt = matrix_calc_pkg::st_drain;
			matrix_calc_pkg::st_copy:
				if (scan_last) state_nxt = matrix_calc_pkg::st_done;
			matrix_calc_pkg::st_play:
				if (scan_last) state_nxt = matrix_calc_pkg::st_idle;
			default:
				state_nxt = matrix_calc_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= matrix_calc_pkg::st_idle;
			scan_row    <= '0;
			scan_col    <= '0;
			pend_valid  <= 1'b0;
			pend_to_cur <= 1'b0;
		end else begin
			state <= state_nxt;
			if (!scan_en || scan_last) begin
				scan_row <= '0;
				scan_col <= '0;
			end else if (scan_col == cmd.dim_m1) begin
				scan_col <= '0;
				scan_row <= scan_row + 4'd1;
			end else begin
				scan_col <= scan_col + 4'd1;
			end
			// setup playback is read-only, every other scan copies
			pend_valid  <= scan_en && !(play_rd && !is_add);
			pend_to_cur <= (state != matrix_calc_pkg::st_permute);
		end
	end

	always_ff @(posedge clk) begin
		pend_addr <= (state == matrix_calc_pkg::st_permute) ? perm_addr : scan_addr;
	end

	// ----------------------------------------------------------------------
	// RAM request muxing
	// ----------------------------------------------------------------------
	always_comb begin
		cur_req  = '0;
		work_req = '0;
		// input beats: setup writes cur, add reads the current element
		if (beat.valid && (state == matrix_calc_pkg::st_idle ||
		                   state == matrix_calc_pkg::st_load) &&
		    (cmd.action == matrix_calc_pkg::act_setup || is_add)) begin
			cur_req.en    = 1'b1;
			cur_req.we    = (cmd.action == matrix_calc_pkg::act_setup);
			cur_req.addr  = {beat.row, beat.col};
			cur_req.wdata = beat.data;
		end
		if (is_add && (state == matrix_calc_pkg::st_load ||
		               state == matrix_calc_pkg::st_drain))
			work_req = add_req;     // folded sums
		if (scan_rd_cur)
			cur_req = '{en: 1'b1, we: 1'b0, addr: scan_addr, wdata: '0};
		if (scan_rd_work)
			work_req = '{en: 1'b1, we: 1'b0, addr: scan_addr, wdata: '0};
		if (pend_valid) begin
			if (pend_to_cur)
				cur_req = '{en: 1'b1, we: 1'b1, addr: pend_addr, wdata: work_rdata};
			else
				work_req = '{en: 1'b1, we: 1'b1, addr: pend_addr, wdata: cur_rdata};
		end
	end

	// no back-pressure, so a new burst must wait for the previous command
	a_cmd_overlap : assert property (@(posedge clk) disable iff (!rst_n)
		beat.valid |-> (state inside {matrix_calc_pkg::st_idle, matrix_calc_pkg::st_load})
		               && !pend_valid)
		else $error("new command before the previous one finished");

	a_port_clash : assert property (@(posedge clk) disable iff (!rst_n)
		pend_valid |-> !(pend_to_cur ? scan_rd_cur : scan_rd_work))
		else $error("copy write collides with a scan read");

endmodule

/* source/mc_output_stage.sv */
`timescale 1ns/10ps

module mc_output_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  matrix_calc_pkg::elem_t cur_rdata,
	input  matrix_calc_pkg::elem_t work_rdata,
	input  logic                   rd_sel,
	input  logic                   play_rd,
	input  logic                   done,
	output logic                   out_valid,
	output matrix_calc_pkg::elem_t out_data
);

	logic play_q;   // rdata this cycle is a playback word
	logic sel_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			play_q    <= 1'b0;
			sel_q     <= 1'b0;
			out_valid <= 1'b0;
			out_data  <= '0;
		end else begin
			play_q    <= play_rd;
			sel_q     <= rd_sel;
			out_valid <= play_q || done;    // done gives a lone zero word
			out_data  <= play_q ? (sel_q ? work_rdata : cur_rdata) : '0;
		end
	end

	a_done_alone : assert property (@(posedge clk) disable iff (!rst_n)
		!(done && play_q))
		else $error("done pulse during playback");

endmodule

/* source/matrix_calc.sv */
`timescale 1ns/10ps

module matrix_calc (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  matrix_calc_pkg::elem_t in_data,
	input  logic [1:0]             size,
	input  logic [2:0]             action,
	output logic                   out_valid,
	output matrix_calc_pkg::elem_t out_data
);

	matrix_calc_pkg::cmd_t     cmd;
	matrix_calc_pkg::beat_t    beat;
	logic                      cmd_end;
	matrix_calc_pkg::ram_req_t add_req;
	matrix_calc_pkg::ram_req_t cur_req, work_req;
	matrix_calc_pkg::elem_t    cur_rdata, work_rdata;
	logic                      rd_sel, play_rd, done;

	// ----------------------------------------------------------------------
	// input side
	// ----------------------------------------------------------------------
	mc_input_stage u_input (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_valid(in_valid),
		.in_data (in_data),
		.size    (size),
		.action  (action),
		.cmd     (cmd),
		.beat    (beat),
		.cmd_end (cmd_end)
	);

	// ----------------------------------------------------------------------
	// processing
	// ----------------------------------------------------------------------
	mc_controller u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.beat      (beat),
		.cmd_end   (cmd_end),
		.add_req   (add_req),
		.cur_rdata (cur_rdata),
		.work_rdata(work_rdata),
		.cur_req   (cur_req),
		.work_req  (work_req),
		.rd_sel    (rd_sel),
		.play_rd   (play_rd),
		.done      (done)
	);

	mc_add_pipe u_add (
		.clk      (clk),
		.rst_n    (rst_n),
		.beat     (beat),
		.cur_rdata(cur_rdata),
		.add_req  (add_req)
	);

	matrix_ram cur_ram (.clk(clk), .req(cur_req), .rdata(cur_rdata));     // current matrix
	matrix_ram work_ram (.clk(clk), .req(work_req), .rdata(work_rdata));  // scratch

	// ----------------------------------------------------------------------
	// output side
	// ----------------------------------------------------------------------
	mc_output_stage u_output (
		.clk       (clk),
		.rst_n     (rst_n),
		.cur_rdata (cur_rdata),
		.work_rdata(work_rdata),
		.rd_sel    (rd_sel),
		.play_rd   (play_rd),
		.done      (done),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

/* verification/matrix_calc_tb.sv */
`timescale 1ns/10ps

module matrix_calc_tb;

	// cycle budget of one command at dimension n
	function automatic int cmd_budget(input int n);
		return 3 * n * n + 30;
	endfunction

	// commands per dimension with the idle check counted as one at N=2
	localparam int TIMEOUT_CYCLES = 2 * cmd_budget(2) + 21 * cmd_budget(4) +
	                                cmd_budget(8) + 9 * cmd_budget(16);

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid;
	matrix_calc_pkg::elem_t in_data;
	logic [1:0]             size;
	logic [2:0]             action;
	logic                   out_valid;
	matrix_calc_pkg::elem_t out_data;

	matrix_calc_pkg::elem_t ref_mat [16][16];   // model of the current matrix
	matrix_calc_pkg::elem_t in_mat  [16][16];   // operand of the next setup or add
	matrix_calc_pkg::elem_t saved   [16][16];
	int                     cur_n;
	int                     cycle_cnt = 0;

	matrix_calc DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_data  (in_data),
		.size     (size),
		.action   (action),
		.out_valid(out_valid),
		.out_data (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$fatal(1, "simulation ran out of cycles");
		end
	end

	// ----------------------------------------------------------------------
	// checking and the reference model
	// ----------------------------------------------------------------------
	task automatic check_val(input string name, input logic [31:0] got,
	                         input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "%s", what);
	endtask

	// 32-bit sum with the carry out folded back into bit 0
	function automatic matrix_calc_pkg::elem_t eac_add(input matrix_calc_pkg::elem_t a,
	                                                   input matrix_calc_pkg::elem_t b);
		logic [31:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[30:0] + {30'd0, s[31]};
	endfunction

	function automatic void permute_model(input matrix_calc_pkg::action_e act);
		matrix_calc_pkg::elem_t tmp [16][16];
		for (int r = 0; r < cur_n; r++) begin
			for (int c = 0; c < cur_n; c++) begin
				case (act)
					matrix_calc_pkg::act_transpose: tmp[c][r] = ref_mat[r][c];
					matrix_calc_pkg::act_mirror:    tmp[r][cur_n - 1 - c] = ref_mat[r][c];
					default:                        tmp[c][cur_n - 1 - r] = ref_mat[r][c];
				endcase
			end
		end
		for (int r = 0; r < cur_n; r++)
			for (int c = 0; c < cur_n; c++)
				ref_mat[r][c] = tmp[r][c];
	endfunction

	function automatic void fill_random(input int n);
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				in_mat[r][c] = matrix_calc_pkg::elem_t'($urandom % 32'h7fff_ffff);
	endfunction

	function automatic void fill_const(input int n, input matrix_calc_pkg::elem_t value);
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				in_mat[r][c] = value;
	endfunction

	// ----------------------------------------------------------------------
	// command drivers
	// ----------------------------------------------------------------------
	task automatic drive_matrix(input int n, input logic [1:0] size_code,
	                            input matrix_calc_pkg::action_e act);
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				@(posedge clk);
				in_valid <= 1'b1;
				in_data  <= in_mat[r][c];
				size     <= size_code;
				action   <= act;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;   // burst end
		in_data  <= '0;
	endtask

	// playback must start within 10 cycles and last exactly n*n cycles
	task automatic collect_matrix(input int n);
		int wait_cnt;
		wait_cnt = 0;
		@(negedge clk);
		while (!out_valid) begin
			wait_cnt++;
			if (wait_cnt > 10)
				abort_run("out_valid never rose after the command");
			@(negedge clk);
		end
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				if (!out_valid)
					abort_run("out_valid dropped before the whole matrix was played");
				check_val("out_data", 32'(out_data), 32'(ref_mat[r][c]));
				@(negedge clk);
			end
		end
		if (out_valid)
			abort_run("out_valid stayed high after the last matrix word");
	endtask

	task automatic send_setup(input logic [1:0] size_code);
		cur_n = 2 << size_code;
		drive_matrix(cur_n, size_code, matrix_calc_pkg::act_setup);
		for (int r = 0; r < cur_n; r++)
			for (int c = 0; c < cur_n; c++)
				ref_mat[r][c] = in_mat[r][c];
		collect_matrix(cur_n);
	endtask

	task automatic send_add();
		drive_matrix(cur_n, 2'd0, matrix_calc_pkg::act_add);
		for (int r = 0; r < cur_n; r++)
			for (int c = 0; c < cur_n; c++)
				ref_mat[r][c] = eac_add(ref_mat[r][c], in_mat[r][c]);
		collect_matrix(cur_n);
	endtask

	// single-beat command that ends with one zero word on out_valid
	task automatic send_perm(input matrix_calc_pkg::action_e act);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge clk);
		in_valid <= 1'b1;
		in_data  <= '0;
		action   <= act;
		@(posedge clk);
		in_valid <= 1'b0;
		permute_model(act);
		@(negedge clk);
		while (!out_valid) begin
			wait_cnt++;
			if (wait_cnt > 2 * cur_n * cur_n + 20)
				abort_run("no done word after a permute command");
			@(negedge clk);
		end
		check_val("out_data", 32'(out_data), 32'd0);
		@(negedge clk);
		if (out_valid)
			abort_run("more than one out_valid cycle after a permute command");
	endtask

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	task automatic idle_after_reset();
		repeat (20) begin
			@(negedge clk);
			check_val("out_valid", 32'(out_valid), 32'd0);
			check_val("out_data", 32'(out_data), 32'd0);
		end
	endtask

	task automatic setup_each_size();
		for (int k = 0; k < 4; k++) begin
			fill_random(2 << k);
			send_setup(2'(k));
		end
	endtask

	task automatic random_add();
		fill_random(cur_n);
		send_add();
	endtask

	task automatic edge_pair_add();
		for (int r = 0; r < 4; r++)     // all-ones and 7ffffffe alternate
			for (int c = 0; c < 4; c++)
				in_mat[r][c] = ((r + c) % 2 == 0) ? 31'h7fff_ffff : 31'h7fff_fffe;
		send_setup(2'd1);
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				in_mat[r][c] = ((r + c) % 2 == 0) ? 31'h7fff_ffff : 31'h0000_0001;
		send_add();
	endtask

	task automatic accumulating_adds();
		fill_random(cur_n);
		send_add();
		fill_random(cur_n);
		send_add();   // builds on the first sum
	endtask

	task automatic permute_sequence(input logic [1:0] size_code);
		fill_random(2 << size_code);
		send_setup(size_code);
		send_perm(matrix_calc_pkg::act_transpose);
		fill_const(cur_n, '0);
		send_add();
		send_perm(matrix_calc_pkg::act_mirror);
		send_add();
		send_perm(matrix_calc_pkg::act_rotate);
		send_add();
	endtask

	task automatic round_trip_identity();
		fill_random(4);
		send_setup(2'd1);
		saved = in_mat;
		repeat (4) send_perm(matrix_calc_pkg::act_rotate);
		ref_mat = saved;    // expect the original back
		fill_const(cur_n, '0);
		send_add();
		repeat (2) send_perm(matrix_calc_pkg::act_mirror);
		ref_mat = saved;
		send_add();
	endtask

	initial begin
		void'($urandom(32'hed22_bfb9));
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		size     = 2'd0;
		action   = 3'd0;
		cur_n    = 2;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		idle_after_reset();
		setup_each_size();
		random_add();
		edge_pair_add();
		accumulating_adds();
		permute_sequence(2'd1);
		permute_sequence(2'd3);
		round_trip_identity();

		$display("TEST OK");
		$finish;
	end

endmodule

/* matrix_calc.f */
source/matrix_calc_pkg.sv
source/mc_input_stage.sv
source/mc_add_pipe.sv
source/matrix_ram.sv
source/mc_controller.sv
source/mc_output_stage.sv
source/matrix_calc.sv
verification/matrix_calc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the matrix_calc testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -sv -f matrix_calc.f --top-module matrix_calc_tb \
	> sim.log 2>&1 &&
	./obj_dir/Vmatrix_calc_tb >> sim.log 2>&1 ||
	echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
